// ==== tb.f ====
rtl/ctrl_regs_pkg.sv
rtl/axil_write_channel.sv
rtl/axil_read_channel.sv
rtl/ctrl_reg_bank.sv
rtl/action_status.sv
rtl/action_ctrl_top.sv
test/action_ctrl_props.sv
test/tb_action_ctrl.sv

// ==== Bender.yml ====
package:
  name: action_ctrl

sources:
  - rtl/ctrl_regs_pkg.sv
  - rtl/axil_write_channel.sv
  - rtl/axil_read_channel.sv
  - rtl/ctrl_reg_bank.sv
  - rtl/action_status.sv
  - rtl/action_ctrl_top.sv
  - target: test
    files:
      - test/action_ctrl_props.sv
      - test/tb_action_ctrl.sv

// ==== test/tb_action_ctrl.sv ====
`timescale 1ns/10ps

module tb_action_ctrl
   import ctrl_regs_pkg::*;
();

   localparam int wait_limit = 200;

   logic       clk = 1'b0;
   logic       rst_n;
   logic [31:0] awaddr;
   logic       awvalid;
   logic       awready;
   word_t      wdata;
   strb_t      wstrb;
   logic       wvalid;
   logic       wready;
   resp_t      bresp;
   logic       bvalid;
   logic       bready;
   logic [31:0] araddr;
   logic       arvalid;
   logic       arready;
   word_t      rdata;
   resp_t      rresp;
   logic       rvalid;
   logic       rready;
   logic       start_pulse;
   wide_addr_t source_address;
   wide_addr_t target_address;
   wide_addr_t dqm_address;
   word_t      mb_w;
   word_t      mb_h;
   dim_t       w1;
   dim_t       w2;
   dim_t       h1;
   logic       done_pulse;
   logic       rd_error;
   logic       wr_error;

   // Register map model, one word per offset slot
   word_t       ref_regs [0:31];
   dim_t        exp_w1;
   dim_t        exp_w2;
   dim_t        exp_h1;
   logic        exp_done;
   logic        exp_rd_err;
   logic        exp_wr_err;
   logic        exp_idle;
   logic        start_seen;
   logic [31:0] rand_state = 32'hea8729c3;

   reg_off_t rw_offs [10] = '{off_snap_control, off_user_control, off_source_lo,
      off_source_hi, off_target_lo, off_target_hi, off_dqm_lo, off_dqm_hi,
      off_mb_w, off_mb_h};

   // 10 ns clock
   always #5 clk = ~clk;

   action_ctrl_top #(.ADDR_WIDTH(32)) UUT (.*);

   // ------------------------------------------------------------------------
   // Failure reporting
   // ------------------------------------------------------------------------
   task automatic report_failure(string what);
      $display("%s", what);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_value(string name, logic [63:0] exp, logic [63:0] got);
      assert (got === exp)
      else begin
         $display("error %s expected %h actual %h", name, exp, got);
         $display("tests failed");
         $fatal(1);
      end
   endtask

   // Bound protocol checks count their own failures
   always @(negedge clk) begin
      if (UUT.u_props.fail_count != 0)
         report_failure("a bound AXI protocol assertion fired");
   end

   // ------------------------------------------------------------------------
   // Reference model
   // ------------------------------------------------------------------------
   function automatic word_t next_random();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   function automatic logic is_writable(reg_off_t off);
      case (off)
         off_snap_control, off_user_control, off_source_lo, off_source_hi,
         off_target_lo, off_target_hi, off_dqm_lo, off_dqm_hi,
         off_mb_w, off_mb_h, off_soft_reset: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic word_t ref_at(reg_off_t off);
      return ref_regs[off[6:2]];
   endfunction

   function automatic void clear_model();
      foreach (ref_regs[i])
         ref_regs[i] = '0;
      exp_w1     = '0;
      exp_w2     = '0;
      exp_h1     = '0;
      exp_done   = 1'b0;
      exp_rd_err = 1'b0;
      exp_wr_err = 1'b0;
      exp_idle   = 1'b0;
   endfunction

   function automatic void model_write(logic [31:0] addr, word_t data, strb_t strb);
      reg_off_t off;
      word_t    merged;
      off = addr[7:0];
      // Outside the window or read-only, nothing changes
      if (addr[31:8] != '0 || !is_writable(off))
         return;
      merged = ref_regs[off[6:2]];
      for (int i = 0; i < 4; i++) begin
         if (strb[i])
            merged[8*i +: 8] = data[8*i +: 8];
      end
      // Start bit only lives for one cycle
      if (off == off_user_control)
         merged[0] = 1'b0;
      ref_regs[off[6:2]] = merged;
      if (off == off_mb_w) begin
         exp_w1 = dim_t'(merged - 32'd1);
         exp_w2 = dim_t'(merged - 32'd2);
      end
      if (off == off_mb_h)
         exp_h1 = dim_t'(merged - 32'd1);
      if (off == off_soft_reset && merged[0])
         clear_model();
   endfunction

   function automatic word_t expect_read(logic [31:0] addr);
      reg_off_t off;
      word_t    stored;
      off    = addr[7:0];
      stored = ref_at(off);
      if (addr[31:8] != '0)
         return unmapped_read_value;
      // Stored upper bits, ready, idle, done as 0, start
      if (off == off_snap_control)
         return {stored[31:4], 1'b1, exp_idle, 1'b0, stored[0]};
      if (off == off_user_status)
         return {29'd0, exp_rd_err, exp_wr_err, exp_done};
      if (is_writable(off))
         return stored;
      return unmapped_read_value;
   endfunction

   // ------------------------------------------------------------------------
   // AXI4-Lite master
   // ------------------------------------------------------------------------
   task automatic axil_write(logic [31:0] addr, word_t data, strb_t strb);
      int    n;
      logic  seen;
      word_t rnd;
      awaddr  = addr;
      awvalid = 1'b1;
      n       = 0;
      seen    = 1'b0;
      while (!seen) begin
         seen = awready;
         @(posedge clk);
         #1;
         n++;
         if (!seen && n > wait_limit)
            report_failure("write address handshake never came");
      end
      awvalid = 1'b0;
      wdata   = data;
      wstrb   = strb;
      wvalid  = 1'b1;
      n       = 0;
      seen    = 1'b0;
      while (!seen) begin
         seen = wready;
         @(posedge clk);
         #1;
         n++;
         if (!seen && n > wait_limit)
            report_failure("write data handshake never came");
      end
      wvalid     = 1'b0;
      // Register updated at this edge
      start_seen = start_pulse;
      model_write(addr, data, strb);
      n    = 0;
      seen = 1'b0;
      while (!seen) begin
         // Random back-pressure on the response
         rnd   = next_random();
         bready = rnd[20];
         seen  = bvalid && bready;
         if (seen)
            check_value("bresp", resp_okay, bresp);
         @(posedge clk);
         #1;
         n++;
         if (!seen && n > wait_limit)
            report_failure("write response handshake never came");
      end
      bready = 1'b0;
   endtask

   task automatic axil_read(logic [31:0] addr, output word_t data);
      int    n;
      logic  seen;
      word_t rnd;
      araddr  = addr;
      arvalid = 1'b1;
      n       = 0;
      seen    = 1'b0;
      while (!seen) begin
         seen = arready;
         @(posedge clk);
         #1;
         n++;
         if (!seen && n > wait_limit)
            report_failure("read address handshake never came");
      end
      arvalid = 1'b0;
      n       = 0;
      seen    = 1'b0;
      while (!seen) begin
         rnd    = next_random();
         rready = rnd[12];
         seen   = rvalid && rready;
         if (seen) begin
            data = rdata;
            check_value("rresp", resp_okay, rresp);
         end
         @(posedge clk);
         #1;
         n++;
         if (!seen && n > wait_limit)
            report_failure("read data handshake never came");
      end
      rready = 1'b0;
   endtask

   task automatic read_check(logic [31:0] addr, string name);
      word_t got;
      axil_read(addr, got);
      check_value(name, expect_read(addr), got);
   endtask

   // Whole window, unmapped slots included
   task automatic read_all(string name);
      for (int i = 0; i < 24; i++)
         read_check(i * 4, $sformatf("%s at %02h", name, i * 4));
   endtask

   task automatic check_outputs(string name);
      check_value({name, " source"}, {ref_at(off_source_hi), ref_at(off_source_lo)},
         source_address);
      check_value({name, " target"}, {ref_at(off_target_hi), ref_at(off_target_lo)},
         target_address);
      check_value({name, " dqm"}, {ref_at(off_dqm_hi), ref_at(off_dqm_lo)}, dqm_address);
      check_value({name, " mb_w"}, ref_at(off_mb_w), mb_w);
      check_value({name, " mb_h"}, ref_at(off_mb_h), mb_h);
      check_value({name, " w1"}, exp_w1, w1);
      check_value({name, " w2"}, exp_w2, w2);
      check_value({name, " h1"}, exp_h1, h1);
   endtask

   // One-cycle pulses on the status inputs
   task automatic pulse_status(logic done, logic rd_err, logic wr_err);
      done_pulse = done;
      rd_error   = rd_err;
      wr_error   = wr_err;
      @(posedge clk);
      #1;
      done_pulse = 1'b0;
      rd_error   = 1'b0;
      wr_error   = 1'b0;
      exp_done   = exp_done | done;
      exp_idle   = exp_idle | done;
      exp_rd_err = exp_rd_err | rd_err;
      exp_wr_err = exp_wr_err | wr_err;
   endtask

   // ------------------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------------------
   initial begin
      word_t got;
      rst_n      = 1'b0;
      awaddr     = '0;
      awvalid    = 1'b0;
      wdata      = '0;
      wstrb      = '0;
      wvalid     = 1'b0;
      bready     = 1'b0;
      araddr     = '0;
      arvalid    = 1'b0;
      rready     = 1'b0;
      done_pulse = 1'b0;
      rd_error   = 1'b0;
      wr_error   = 1'b0;
      start_seen = 1'b0;
      clear_model();
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(posedge clk);
      #1;
      read_all("after reset");
      check_outputs("after reset");

      // Full words, every writable slot, whole map read after each
      for (int round = 0; round < 2; round++) begin
         foreach (rw_offs[i]) begin
            axil_write(rw_offs[i], next_random(), 4'hF);
            read_all("full strobe");
            check_outputs("full strobe");
         end
      end

      // Byte lanes
      axil_write(off_mb_w, next_random(), 4'b0101);
      axil_write(off_source_hi, next_random(), 4'b1000);
      axil_write(off_target_lo, next_random(), 4'b0110);
      read_all("partial strobe");
      check_outputs("partial strobe");

      // Unmapped, read-only and out of window
      read_check(32'h0000_00FC, "unmapped read");
      read_check(32'h0000_0150, "out of window read");
      axil_write(32'h0000_0004, next_random(), 4'hF);
      axil_write(off_user_status, next_random(), 4'hF);
      axil_write(32'h0000_0138, next_random(), 4'hF);
      read_all("ignored writes");
      check_outputs("ignored writes");

      // Derived dimensions wrap at 10 bits
      axil_write(off_mb_w, 32'd1, 4'hF);
      axil_write(off_mb_h, 32'h0000_0400, 4'hF);
      check_outputs("dimensions");
      check_value("w2 wrap", 64'h3FF, w2);
      check_value("h1 wrap", 64'h3FF, h1);

      // Start pulse
      axil_write(off_user_control, 32'h0000_0011, 4'hF);
      check_value("start pulse", 64'd1, start_seen);
      check_value("start pulse end", 64'd0, start_pulse);
      read_check(off_user_control, "start bit cleared");

      // Sticky status and snap readback
      axil_write(off_snap_control, 32'h0000_0001, 4'hF);
      read_check(off_snap_control, "snap start");
      pulse_status(1'b1, 1'b0, 1'b0);
      read_check(off_user_status, "done sticky");
      pulse_status(1'b0, 1'b1, 1'b0);
      pulse_status(1'b0, 1'b0, 1'b1);
      read_all("sticky status");

      // Soft reset clears everything
      axil_write(off_soft_reset, 32'h0000_0001, 4'hF);
      read_all("soft reset");
      check_outputs("soft reset");
      axil_read(off_snap_control, got);
      check_value("snap after soft reset", 64'h8, got);

      if (UUT.u_props.fail_count == 0) begin
         $display("all tests passed");
         $finish;
      end else begin
         report_failure("a bound AXI protocol assertion fired");
      end
   end

endmodule

// ==== test/action_ctrl_props.sv ====
`timescale 1ns/10ps

module action_ctrl_props
   import ctrl_regs_pkg::*;
(
   input logic  clk,
   input logic  rst_n,
   input logic  awready,
   input logic  bvalid,
   input logic  bready,
   input logic  rvalid,
   input logic  rready,
   input word_t rdata,
   input logic  start_pulse
);

   // Number of fired properties
   int unsigned fail_count = 0;

   // ------------------------------------------------------------------------
   // Response channels
   // ------------------------------------------------------------------------

   // Write response held until taken
   b_hold: assert property (@(posedge clk) disable iff (!rst_n)
      bvalid && !bready |=> bvalid)
   else begin
      fail_count++;
      $error("bvalid dropped before bready");
   end

   // Read data held until taken
   r_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rvalid && !rready |=> rvalid)
   else begin
      fail_count++;
      $error("rvalid dropped before rready");
   end

   r_stable: assert property (@(posedge clk) disable iff (!rst_n)
      rvalid && !rready |=> $stable(rdata))
   else begin
      fail_count++;
      $error("rdata changed while stalled");
   end

   // No new address while a response is pending
   aw_blocked: assert property (@(posedge clk) disable iff (!rst_n)
      bvalid |-> !awready)
   else begin
      fail_count++;
      $error("awready high with bvalid pending");
   end

   // ------------------------------------------------------------------------
   // Local control
   // ------------------------------------------------------------------------
   start_single: assert property (@(posedge clk) disable iff (!rst_n)
      start_pulse |=> !start_pulse)
   else begin
      fail_count++;
      $error("start_pulse longer than one cycle");
   end

endmodule

bind action_ctrl_top action_ctrl_props u_props (
   .clk, .rst_n, .awready, .bvalid, .bready,
   .rvalid, .rready, .rdata, .start_pulse
);

// ==== rtl/action_ctrl_top.sv ====
`timescale 1ns/10ps

module action_ctrl_top
   import ctrl_regs_pkg::*;
#(
   parameter int ADDR_WIDTH = 32
) (
   input  logic                  clk,
   input  logic                  rst_n,
   // AXI4-Lite slave
   input  logic [ADDR_WIDTH-1:0] awaddr,
   input  logic                  awvalid,
   output logic                  awready,
   input  word_t                 wdata,
   input  strb_t                 wstrb,
   input  logic                  wvalid,
   output logic                  wready,
   output resp_t                 bresp,
   output logic                  bvalid,
   input  logic                  bready,
   input  logic [ADDR_WIDTH-1:0] araddr,
   input  logic                  arvalid,
   output logic                  arready,
   output word_t                 rdata,
   output resp_t                 rresp,
   output logic                  rvalid,
   input  logic                  rready,
   // Local control
   output logic                  start_pulse,
   output wide_addr_t            source_address,
   output wide_addr_t            target_address,
   output wide_addr_t            dqm_address,
   output word_t                 mb_w,
   output word_t                 mb_h,
   output dim_t                  w1,
   output dim_t                  w2,
   output dim_t                  h1,
   // Local status
   input  logic                  done_pulse,
   input  logic                  rd_error,
   input  logic                  wr_error
);

   // Register write port
   logic     reg_wr_en;
   reg_off_t reg_wr_addr;
   word_t    reg_wr_data;
   strb_t    reg_wr_strb;

   // Stored and status words
   logic  snap_start_req;
   logic  soft_reset;
   word_t snap_control_word;
   word_t user_control;
   word_t soft_reset_word;
   word_t user_status;
   word_t snap_control_rd;

   // No error responses in this block
   assign bresp = resp_okay;
   assign rresp = resp_okay;

   // ------------------------------------------------------------------------
   // Bus side
   // ------------------------------------------------------------------------
   axil_write_channel #(.ADDR_WIDTH(ADDR_WIDTH)) u_write (
      .clk, .rst_n,
      .awaddr, .awvalid, .awready,
      .wdata, .wstrb, .wvalid, .wready,
      .bvalid, .bready,
      .reg_wr_en, .reg_wr_addr, .reg_wr_data, .reg_wr_strb
   );

   axil_read_channel #(.ADDR_WIDTH(ADDR_WIDTH)) u_read (
      .clk, .rst_n,
      .araddr, .arvalid, .arready,
      .rdata, .rvalid, .rready,
      .snap_control_rd, .user_status, .user_control,
      .source_address, .target_address, .dqm_address,
      .mb_w, .mb_h, .soft_reset_word
   );

   // ------------------------------------------------------------------------
   // Storage and status
   // ------------------------------------------------------------------------
   ctrl_reg_bank u_regs (
      .clk, .rst_n,
      .reg_wr_en, .reg_wr_addr, .reg_wr_data, .reg_wr_strb,
      .snap_start_req, .snap_control_word, .user_control, .soft_reset_word,
      .source_address, .target_address, .dqm_address,
      .mb_w, .mb_h, .w1, .w2, .h1,
      .start_pulse, .soft_reset
   );

   action_status u_status (
      .clk, .rst_n,
      .soft_reset, .snap_start_req, .snap_control_word,
      .done_pulse, .rd_error, .wr_error,
      .user_status, .snap_control_rd
   );

endmodule

// ==== rtl/action_status.sv ====
`timescale 1ns/10ps

module action_status
   import ctrl_regs_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  soft_reset,
   input  logic  snap_start_req,
   input  word_t snap_control_word,
   // Pulses from the action
   input  logic  done_pulse,
   input  logic  rd_error,
   input  logic  wr_error,
   output word_t user_status,
   output word_t snap_control_rd
);

   logic done_q;
   logic wr_error_q;
   logic rd_error_q;
   logic snap_idle_q;
   logic snap_start_q;

   // ------------------------------------------------------------------------
   // Sticky flags, cleared only by reset
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         done_q       <= 1'b0;
         wr_error_q   <= 1'b0;
         rd_error_q   <= 1'b0;
         snap_idle_q  <= 1'b0;
         snap_start_q <= 1'b0;
      end else if (soft_reset) begin
         done_q       <= 1'b0;
         wr_error_q   <= 1'b0;
         rd_error_q   <= 1'b0;
         snap_idle_q  <= 1'b0;
         snap_start_q <= 1'b0;
      end else begin
         // Set and hold
         done_q       <= done_q | done_pulse;
         wr_error_q   <= wr_error_q | wr_error;
         rd_error_q   <= rd_error_q | rd_error;
         // Action finished, snap goes idle
         snap_idle_q  <= snap_idle_q | done_pulse;
         // Start bit seen one cycle late
         snap_start_q <= snap_start_req;
      end
   end

   assign user_status = {29'd0, rd_error_q, wr_error_q, done_q};

   // Upper bits as stored, ready always set, done bit reads 0
   always_comb begin
      snap_control_rd                 = {snap_control_word[31:4], 4'b0000};
      snap_control_rd[snap_ready_bit] = 1'b1;
      snap_control_rd[snap_idle_bit]  = snap_idle_q;
      snap_control_rd[snap_start_bit] = snap_start_q;
   end

endmodule

// ==== rtl/ctrl_reg_bank.sv ====
`timescale 1ns/10ps

module ctrl_reg_bank
   import ctrl_regs_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   // Write port from the AXI write channel
   input  logic       reg_wr_en,
   input  reg_off_t   reg_wr_addr,
   input  word_t      reg_wr_data,
   input  strb_t      reg_wr_strb,
   // Stored words
   output logic       snap_start_req,
   output word_t      snap_control_word,
   output word_t      user_control,
   output word_t      soft_reset_word,
   output wide_addr_t source_address,
   output wide_addr_t target_address,
   output wide_addr_t dqm_address,
   output word_t      mb_w,
   output word_t      mb_h,
   // Derived dimensions
   output dim_t       w1,
   output dim_t       w2,
   output dim_t       h1,
   output logic       start_pulse,
   output logic       soft_reset
);

   word_t old_word;
   word_t wr_word;

   // Replace only the strobed byte lanes
   function automatic word_t merge_bytes(word_t old_val, word_t new_val, strb_t strb);
      word_t result;
      result = old_val;
      for (int i = 0; i < $bits(strb_t); i++) begin
         if (strb[i])
            result[8*i +: 8] = new_val[8*i +: 8];
      end
      return result;
   endfunction

   // ------------------------------------------------------------------------
   // Current value of the addressed word
   // ------------------------------------------------------------------------
   always_comb begin
      case (reg_wr_addr)
         off_snap_control: old_word = snap_control_word;
         off_user_control: old_word = user_control;
         off_source_lo:    old_word = source_address[31:0];
         off_source_hi:    old_word = source_address[63:32];
         off_target_lo:    old_word = target_address[31:0];
         off_target_hi:    old_word = target_address[63:32];
         off_dqm_lo:       old_word = dqm_address[31:0];
         off_dqm_hi:       old_word = dqm_address[63:32];
         off_mb_w:         old_word = mb_w;
         off_mb_h:         old_word = mb_h;
         off_soft_reset:   old_word = soft_reset_word;
         default:          old_word = '0;
      endcase
   end

   assign wr_word = merge_bytes(old_word, reg_wr_data, reg_wr_strb);

   // ------------------------------------------------------------------------
   // Register storage
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         snap_control_word <= '0;
         user_control      <= '0;
         source_address    <= '0;
         target_address    <= '0;
         dqm_address       <= '0;
         mb_w              <= '0;
         mb_h              <= '0;
         soft_reset_word   <= '0;
         w1                <= '0;
         w2                <= '0;
         h1                <= '0;
      end else if (soft_reset) begin
         // Soft reset also clears its own trigger
         snap_control_word <= '0;
         user_control      <= '0;
         source_address    <= '0;
         target_address    <= '0;
         dqm_address       <= '0;
         mb_w              <= '0;
         mb_h              <= '0;
         soft_reset_word   <= '0;
         w1                <= '0;
         w2                <= '0;
         h1                <= '0;
      end else if (reg_wr_en) begin
         case (reg_wr_addr)
            off_snap_control: snap_control_word     <= wr_word;
            off_user_control: user_control          <= wr_word;
            // Each half of a wide address on its own
            off_source_lo:    source_address[31:0]  <= wr_word;
            off_source_hi:    source_address[63:32] <= wr_word;
            off_target_lo:    target_address[31:0]  <= wr_word;
            off_target_hi:    target_address[63:32] <= wr_word;
            off_dqm_lo:       dqm_address[31:0]     <= wr_word;
            off_dqm_hi:       dqm_address[63:32]    <= wr_word;
            off_mb_w: begin
               mb_w <= wr_word;
               // Truncated to the dimension width
               w1   <= dim_t'(wr_word - 32'd1);
               w2   <= dim_t'(wr_word - 32'd2);
            end
            off_mb_h: begin
               mb_h <= wr_word;
               h1   <= dim_t'(wr_word - 32'd1);
            end
            off_soft_reset:   soft_reset_word       <= wr_word;
            // Read-only and unmapped offsets ignored
            default: ;
         endcase
      end else begin
         // Start bit self-clears, one cycle wide
         user_control[0] <= 1'b0;
      end
   end

   assign start_pulse    = user_control[0];
   assign soft_reset     = soft_reset_word[0];
   assign snap_start_req = snap_control_word[snap_start_bit];

endmodule

// ==== rtl/axil_read_channel.sv ====
`timescale 1ns/10ps

module axil_read_channel
   import ctrl_regs_pkg::*;
#(
   parameter int ADDR_WIDTH = 32
) (
   input  logic                  clk,
   input  logic                  rst_n,
   // Read address channel
   input  logic [ADDR_WIDTH-1:0] araddr,
   input  logic                  arvalid,
   output logic                  arready,
   // Read data channel
   output word_t                 rdata,
   output logic                  rvalid,
   input  logic                  rready,
   // Register sources
   input  word_t                 snap_control_rd,
   input  word_t                 user_status,
   input  word_t                 user_control,
   input  wide_addr_t            source_address,
   input  wide_addr_t            target_address,
   input  wide_addr_t            dqm_address,
   input  word_t                 mb_w,
   input  word_t                 mb_h,
   input  word_t                 soft_reset_word
);

   localparam int off_w = $bits(reg_off_t);

   typedef enum logic {idle_addr, wait_ready} rd_state_t;

   rd_state_t state;
   word_t     rd_word;

   assign arready = (state == idle_addr);
   assign rvalid  = (state == wait_ready);

   // ------------------------------------------------------------------------
   // Handshake sequencing
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= idle_addr;
      end else begin
         case (state)
            idle_addr:
               if (arvalid)
                  state <= wait_ready;
            // Data held until the master takes it
            wait_ready:
               if (rready)
                  state <= idle_addr;
            default:
               state <= idle_addr;
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // Read decode
   // ------------------------------------------------------------------------
   always_comb begin
      rd_word = unmapped_read_value;
      // Only addresses inside the window can hit a register
      if (araddr[ADDR_WIDTH-1:off_w] == '0) begin
         case (araddr[off_w-1:0])
            off_snap_control: rd_word = snap_control_rd;
            off_user_status:  rd_word = user_status;
            off_user_control: rd_word = user_control;
            // Wide addresses as two words
            off_source_lo:    rd_word = source_address[31:0];
            off_source_hi:    rd_word = source_address[63:32];
            off_target_lo:    rd_word = target_address[31:0];
            off_target_hi:    rd_word = target_address[63:32];
            off_dqm_lo:       rd_word = dqm_address[31:0];
            off_dqm_hi:       rd_word = dqm_address[63:32];
            off_mb_w:         rd_word = mb_w;
            off_mb_h:         rd_word = mb_h;
            off_soft_reset:   rd_word = soft_reset_word;
            default:          rd_word = unmapped_read_value;
         endcase
      end
   end

   // Loaded on the AR handshake, stable while rvalid waits
   always_ff @(posedge clk) begin
      if (arvalid && arready) begin
         rdata <= rd_word;
      end
   end

endmodule

// ==== rtl/axil_write_channel.sv ====
`timescale 1ns/10ps

module axil_write_channel
   import ctrl_regs_pkg::*;
#(
   parameter int ADDR_WIDTH = 32
) (
   input  logic                  clk,
   input  logic                  rst_n,
   // Write address channel
   input  logic [ADDR_WIDTH-1:0] awaddr,
   input  logic                  awvalid,
   output logic                  awready,
   // Write data channel
   input  word_t                 wdata,
   input  strb_t                 wstrb,
   input  logic                  wvalid,
   output logic                  wready,
   // Write response channel
   output logic                  bvalid,
   input  logic                  bready,
   // Register write port
   output logic                  reg_wr_en,
   output reg_off_t              reg_wr_addr,
   output word_t                 reg_wr_data,
   output strb_t                 reg_wr_strb
);

   localparam int off_w = $bits(reg_off_t);

   typedef enum logic [1:0] {idle_addr, wait_data, wait_resp} wr_state_t;

   wr_state_t state;
   wr_state_t state_nxt;
   reg_off_t  addr_q;
   logic      addr_bad_q;

   // Ready and valid come straight from the state
   assign awready = (state == idle_addr);
   assign wready  = (state == wait_data);
   assign bvalid  = (state == wait_resp);

   // ------------------------------------------------------------------------
   // Handshake sequencing
   // ------------------------------------------------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         idle_addr:
            if (awvalid)
               state_nxt = wait_data;
         wait_data:
            if (wvalid)
               state_nxt = wait_resp;
         // Hold the response, no new address meanwhile
         wait_resp:
            if (bready)
               state_nxt = idle_addr;
         default:
            state_nxt = idle_addr;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= idle_addr;
      end else begin
         state <= state_nxt;
      end
   end

   // Address capture on the AW handshake
   always_ff @(posedge clk) begin
      if (awvalid && awready) begin
         addr_q     <= awaddr[off_w-1:0];
         // Any upper bit set puts the access outside the window
         addr_bad_q <= (awaddr[ADDR_WIDTH-1:off_w] != '0);
      end
   end

   // One strobe per burst, in the W handshake cycle
   assign reg_wr_en   = wvalid && wready;
   // All ones is not a word offset, so nothing in the bank matches
   assign reg_wr_addr = addr_bad_q ? '1 : addr_q;
   assign reg_wr_data = wdata;
   assign reg_wr_strb = wstrb;

endmodule

// ==== rtl/ctrl_regs_pkg.sv ====
package ctrl_regs_pkg;

   // ------------------------------------------------------------------------
   // Word and field types
   // ------------------------------------------------------------------------

   // One register word, always 32 bits wide
   typedef logic [31:0] word_t;
   // Byte lanes of a word
   typedef logic [3:0]  strb_t;
   // Buffer address held as two words
   typedef logic [63:0] wide_addr_t;
   // Derived macroblock dimension
   typedef logic [9:0]  dim_t;
   typedef logic [1:0]  resp_t;
   // Byte offset inside the register window
   typedef logic [7:0]  reg_off_t;

   // Both channels only ever answer OKAY
   localparam resp_t resp_okay = 2'b00;

   // ------------------------------------------------------------------------
   // Register offsets
   // ------------------------------------------------------------------------
   localparam reg_off_t off_snap_control = 8'h00;
   localparam reg_off_t off_user_status  = 8'h30;
   localparam reg_off_t off_user_control = 8'h34;
   localparam reg_off_t off_source_lo    = 8'h38;
   localparam reg_off_t off_source_hi    = 8'h3C;
   localparam reg_off_t off_target_lo    = 8'h40;
   localparam reg_off_t off_target_hi    = 8'h44;
   localparam reg_off_t off_dqm_lo       = 8'h48;
   localparam reg_off_t off_dqm_hi       = 8'h4C;
   localparam reg_off_t off_mb_w         = 8'h50;
   localparam reg_off_t off_mb_h         = 8'h54;
   localparam reg_off_t off_soft_reset   = 8'h58;

   // Pattern for reads that hit nothing
   localparam word_t unmapped_read_value = 32'h5A5A_A5A5;

   // Snap control readback bits
   localparam int snap_start_bit = 0;
   localparam int snap_idle_bit  = 2;
   localparam int snap_ready_bit = 3;

endpackage
